// File: common/cu_pkg.sv
// Shared widths, instruction fields, opcodes, FSM states and APB map used by every unit
`default_nettype none

package cu_pkg;

    localparam int WORD_W       = 20;  // General register width
    localparam int INSTR_W      = 20;
    localparam int REG_SEL_W    = 3;   // Register field in the instruction
    localparam int OPC_W        = 6;
    localparam int NUM_REGS_DEF = 6;

    // Field LSBs, opcode at the top
    localparam int OPC_LSB  = 14;
    localparam int SRC1_LSB = 11;
    localparam int SRC2_LSB = 8;
    localparam int DST1_LSB = 5;
    localparam int DST2_LSB = 2;       // Bits 1:0 mode and extra, ignored

    typedef enum logic [OPC_W-1:0] {
        TRAP_OP  = 6'd0,               // Sticky trap, refuses later instructions
        NOP_OP   = 6'd1,
        JMP_OP   = 6'd2,               // Jumps and status ops decode as NOP
        JMPZ_OP  = 6'd3,
        JMPS_OP  = 6'd4,
        JMPZS_OP = 6'd5,
        LSTAT_OP = 6'd6,
        XSTAT_OP = 6'd7,
        NOT_OP   = 6'd8,
        AND_OP   = 6'd9,
        OR_OP    = 6'd10,
        XOR_OP   = 6'd11,
        SHFTR_OP = 6'd12,
        SHFTL_OP = 6'd13,
        ROTR_OP  = 6'd14,
        ROTL_OP  = 6'd15,
        SWAP_OP  = 6'd16,
        INC_OP   = 6'd17,
        DEC_OP   = 6'd18,
        ADD_OP   = 6'd19,              // Arithmetic group, no effect
        ADDC_OP  = 6'd20,
        SUB_OP   = 6'd21,
        SUBC_OP  = 6'd22,
        EQ_OP    = 6'd23,
        GT_OP    = 6'd24,
        LT_OP    = 6'd25,
        GET_OP   = 6'd26,
        LET_OP   = 6'd27
    } opcode_t;

    typedef enum logic [1:0] {
        S_FETCH      = 2'd0,           // Idle here between instructions
        S_DECODE     = 2'd1,
        S_EXECUTE    = 2'd2,
        S_WRITE_BACK = 2'd3
    } seq_state_t;

    // APB side
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;
    localparam logic [APB_ADDR_W-1:0] ADDR_INSTR    = 8'h00;  // Write only
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS   = 8'h04;  // Read only, {trap,carry,sign,zero}
    localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 8'h10;  // Reg n at base + 4n

endpackage

`default_nettype wire

// File: datapath/cu_alu.sv
// Combinational ALU, gives results, destination writes and flag updates per opcode
`timescale 1ns/1ps
`default_nettype none

module cu_alu (
    input  wire [cu_pkg::OPC_W-1:0]   opcode,
    input  wire [cu_pkg::WORD_W-1:0]  op_a,
    input  wire [cu_pkg::WORD_W-1:0]  op_b,
    output logic [cu_pkg::WORD_W-1:0] result_a,
    output logic [cu_pkg::WORD_W-1:0] result_b,
    output logic                      write_a,
    output logic                      write_b,
    output logic                      zero_upd,
    output logic                      zero_val,
    output logic                      sign_upd,
    output logic                      sign_val,
    output logic                      carry_upd,
    output logic                      carry_val
);

    localparam int W = cu_pkg::WORD_W;

    logic [W:0]   inc_sum;   // Carry out in the top bit
    logic [W-1:0] dec_diff;  // Wraps to all ones

    assign inc_sum  = {1'b0, op_a} + 1'b1;
    assign dec_diff = op_a - 1'b1;

    always_comb begin
        result_a  = '0;
        result_b  = '0;
        write_a   = 1'b0;
        write_b   = 1'b0;
        zero_upd  = 1'b0;
        zero_val  = 1'b0;
        sign_upd  = 1'b0;
        sign_val  = 1'b0;
        carry_upd = 1'b0;
        carry_val = 1'b0;
        case (opcode)
            cu_pkg::NOT_OP: begin
                result_a = ~op_a;
                write_a  = 1'b1;
                zero_upd = 1'b1;
            end
            cu_pkg::AND_OP: begin
                result_a = op_a & op_b;
                write_a  = 1'b1;
                zero_upd = 1'b1;
            end
            cu_pkg::OR_OP: begin
                result_a = op_a | op_b;
                write_a  = 1'b1;
                zero_upd = 1'b1;
            end
            cu_pkg::XOR_OP: begin
                result_a = op_a ^ op_b;
                write_a  = 1'b1;
                zero_upd = 1'b1;
            end
            cu_pkg::SHFTR_OP: begin
                result_a  = {1'b0, op_a[W-1:1]};
                carry_val = op_a[0];     // Bit shifted out
                write_a   = 1'b1;
                zero_upd  = 1'b1;
                carry_upd = 1'b1;
            end
            cu_pkg::SHFTL_OP: begin
                result_a  = {op_a[W-2:0], 1'b0};
                carry_val = op_a[W-1];
                write_a   = 1'b1;
                zero_upd  = 1'b1;
                carry_upd = 1'b1;
            end
            cu_pkg::ROTR_OP: begin
                result_a = {op_a[0], op_a[W-1:1]};  // Flags untouched
                write_a  = 1'b1;
            end
            cu_pkg::ROTL_OP: begin
                result_a = {op_a[W-2:0], op_a[W-1]};
                write_a  = 1'b1;
            end
            cu_pkg::SWAP_OP: begin
                result_a = op_b;
                result_b = op_a;
                write_a  = 1'b1;
                write_b  = 1'b1;
            end
            cu_pkg::INC_OP: begin
                result_a  = inc_sum[W-1:0];
                carry_val = inc_sum[W];
                write_a   = 1'b1;
                zero_upd  = 1'b1;
                carry_upd = 1'b1;
            end
            cu_pkg::DEC_OP: begin
                result_a  = dec_diff;
                carry_val = (op_a == '0);  // Borrow
                write_a   = 1'b1;
                zero_upd  = 1'b1;
                carry_upd = 1'b1;
            end
            // Unsigned compares, flags only
            cu_pkg::EQ_OP: begin
                zero_upd = 1'b1;
                zero_val = (op_a == op_b);
            end
            cu_pkg::GT_OP: begin
                sign_upd = 1'b1;
                sign_val = (op_a > op_b);
            end
            cu_pkg::LT_OP: begin
                sign_upd = 1'b1;
                sign_val = (op_a < op_b);
            end
            cu_pkg::GET_OP: begin
                sign_upd = 1'b1;
                sign_val = (op_a >= op_b);
                zero_upd = 1'b1;
                zero_val = (op_a == op_b);
            end
            cu_pkg::LET_OP: begin
                sign_upd = 1'b1;
                sign_val = (op_a <= op_b);
                zero_upd = 1'b1;
                zero_val = (op_a == op_b);
            end
            default: ;  // TRAP, NOP and dropped opcodes
        endcase
        // Zero of the written result for the logic, shift and inc/dec group
        if (zero_upd && write_a) begin
            zero_val = (result_a == '0);
        end
    end

endmodule

`default_nettype wire

// File: datapath/cu_regfile.sv
// General register file with two operand reads, two write-back ports and a host port
`timescale 1ns/1ps
`default_nettype none

module cu_regfile #(
    parameter int NUM_REGS = cu_pkg::NUM_REGS_DEF
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire [cu_pkg::REG_SEL_W-1:0]  rd_sel_a,
    input  wire [cu_pkg::REG_SEL_W-1:0]  rd_sel_b,
    input  wire                          wb_we_a,
    input  wire [cu_pkg::REG_SEL_W-1:0]  wb_sel_a,
    input  wire [cu_pkg::WORD_W-1:0]     wb_data_a,
    input  wire                          wb_we_b,
    input  wire [cu_pkg::REG_SEL_W-1:0]  wb_sel_b,
    input  wire [cu_pkg::WORD_W-1:0]     wb_data_b,
    input  wire                          host_we,
    input  wire [cu_pkg::REG_SEL_W-1:0]  host_sel,
    input  wire [cu_pkg::WORD_W-1:0]     host_data,
    output logic [cu_pkg::WORD_W-1:0]    rd_data_a,
    output logic [cu_pkg::WORD_W-1:0]    rd_data_b,
    output logic [cu_pkg::WORD_W-1:0]    host_rdata
);

    localparam int SEL_W = cu_pkg::REG_SEL_W;

    logic [cu_pkg::WORD_W-1:0] regs [NUM_REGS];

    // Out-of-range selector reads zero
    function automatic logic [cu_pkg::WORD_W-1:0] read_reg(input logic [SEL_W-1:0] sel);
        logic [cu_pkg::WORD_W-1:0] val;
        val = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (sel == SEL_W'(i)) begin
                val = regs[i];
            end
        end
        return val;
    endfunction

    always_comb rd_data_a  = read_reg(rd_sel_a);
    always_comb rd_data_b  = read_reg(rd_sel_b);
    always_comb host_rdata = read_reg(host_sel);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (host_we && host_sel == SEL_W'(i)) begin
                    regs[i] <= host_data;
                end
                if (wb_we_a && wb_sel_a == SEL_W'(i)) begin
                    regs[i] <= wb_data_a;
                end
                if (wb_we_b && wb_sel_b == SEL_W'(i)) begin
                    regs[i] <= wb_data_b;  // Last, so port b wins
                end
            end
        end
    end

    // Host access only between instructions
    assert property (@(posedge clk) disable iff (reset)
        host_we |-> !(wb_we_a || wb_we_b));

endmodule

`default_nettype wire

// File: control/cu_sequencer.sv
// Four-state instruction FSM, latches operands and results and owns the status flags
`timescale 1ns/1ps
`default_nettype none

module cu_sequencer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           start,
    input  wire [cu_pkg::INSTR_W-1:0]     instr,
    input  wire [cu_pkg::WORD_W-1:0]      rd_data_a,
    input  wire [cu_pkg::WORD_W-1:0]      rd_data_b,
    input  wire [cu_pkg::WORD_W-1:0]      result_a,
    input  wire [cu_pkg::WORD_W-1:0]      result_b,
    input  wire                           write_a,
    input  wire                           write_b,
    input  wire                           zero_upd,
    input  wire                           zero_val,
    input  wire                           sign_upd,
    input  wire                           sign_val,
    input  wire                           carry_upd,
    input  wire                           carry_val,
    output logic                          done,
    output logic                          zero_flag,
    output logic                          sign_flag,
    output logic                          carry_flag,
    output logic                          trap_flag,
    output logic [cu_pkg::REG_SEL_W-1:0]  rd_sel_a,
    output logic [cu_pkg::REG_SEL_W-1:0]  rd_sel_b,
    output logic                          wb_we_a,
    output logic [cu_pkg::REG_SEL_W-1:0]  wb_sel_a,
    output logic [cu_pkg::WORD_W-1:0]     wb_data_a,
    output logic                          wb_we_b,
    output logic [cu_pkg::REG_SEL_W-1:0]  wb_sel_b,
    output logic [cu_pkg::WORD_W-1:0]     wb_data_b,
    output cu_pkg::opcode_t               opcode,
    output logic [cu_pkg::WORD_W-1:0]     op_a,
    output logic [cu_pkg::WORD_W-1:0]     op_b
);

    cu_pkg::seq_state_t         state;
    logic [cu_pkg::INSTR_W-1:0] instr_q;
    logic [cu_pkg::WORD_W-1:0]  res_a_q;
    logic [cu_pkg::WORD_W-1:0]  res_b_q;
    logic                       wr_a_q;
    logic                       wr_b_q;
    logic                       zu_q;    // Latched flag updates
    logic                       zv_q;
    logic                       su_q;
    logic                       sv_q;
    logic                       cu_q;
    logic                       cv_q;

    // Instruction fields
    assign opcode   = cu_pkg::opcode_t'(instr_q[cu_pkg::OPC_LSB +: cu_pkg::OPC_W]);
    assign rd_sel_a = instr_q[cu_pkg::SRC1_LSB +: cu_pkg::REG_SEL_W];
    assign rd_sel_b = instr_q[cu_pkg::SRC2_LSB +: cu_pkg::REG_SEL_W];
    assign wb_sel_a = instr_q[cu_pkg::DST1_LSB +: cu_pkg::REG_SEL_W];
    assign wb_sel_b = instr_q[cu_pkg::DST2_LSB +: cu_pkg::REG_SEL_W];

    assign done      = (state == cu_pkg::S_WRITE_BACK);
    assign wb_we_a   = done && wr_a_q;
    assign wb_we_b   = done && wr_b_q;
    assign wb_data_a = res_a_q;
    assign wb_data_b = res_b_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= cu_pkg::S_FETCH;
            wr_a_q     <= 1'b0;
            wr_b_q     <= 1'b0;
            zu_q       <= 1'b0;
            zv_q       <= 1'b0;
            su_q       <= 1'b0;
            sv_q       <= 1'b0;
            cu_q       <= 1'b0;
            cv_q       <= 1'b0;
            zero_flag  <= 1'b0;
            sign_flag  <= 1'b0;
            carry_flag <= 1'b0;
            trap_flag  <= 1'b0;
        end else begin
            case (state)
                cu_pkg::S_FETCH: begin
                    if (start) begin
                        state <= cu_pkg::S_DECODE;
                    end
                end
                cu_pkg::S_DECODE: state <= cu_pkg::S_EXECUTE;  // Operands latched below
                cu_pkg::S_EXECUTE: begin
                    state  <= cu_pkg::S_WRITE_BACK;
                    wr_a_q <= write_a;
                    wr_b_q <= write_b;
                    zu_q   <= zero_upd;
                    zv_q   <= zero_val;
                    su_q   <= sign_upd;
                    sv_q   <= sign_val;
                    cu_q   <= carry_upd;
                    cv_q   <= carry_val;
                end
                default: begin
                    state <= cu_pkg::S_FETCH;  // Write-back, regs written by the regfile
                    if (zu_q) begin
                        zero_flag <= zv_q;
                    end
                    if (su_q) begin
                        sign_flag <= sv_q;
                    end
                    if (cu_q) begin
                        carry_flag <= cv_q;
                    end
                    if (opcode == cu_pkg::TRAP_OP) begin
                        trap_flag <= 1'b1;  // Sticky until reset
                    end
                end
            endcase
        end
    end

    // Instruction, operand and result data
    always_ff @(posedge clk) begin
        if (state == cu_pkg::S_FETCH && start) begin
            instr_q <= instr;
        end
        if (state == cu_pkg::S_DECODE) begin
            op_a <= rd_data_a;
            op_b <= rd_data_b;
        end
        if (state == cu_pkg::S_EXECUTE) begin
            res_a_q <= result_a;
            res_b_q <= result_b;
        end
    end

    // Port issues only while idle
    assert property (@(posedge clk) disable iff (reset)
        start |-> (state == cu_pkg::S_FETCH));

endmodule

`default_nettype wire

// File: hdl/cu_apb_port.sv
// APB slave of the control unit, decodes the map, issues instructions and serves host reads
`timescale 1ns/1ps
`default_nettype none

module cu_apb_port #(
    parameter int NUM_REGS = cu_pkg::NUM_REGS_DEF
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [cu_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire [cu_pkg::APB_DATA_W-1:0]  pwdata,
    input  wire                           done,
    input  wire                           trap_flag,
    input  wire                           zero_flag,
    input  wire                           sign_flag,
    input  wire                           carry_flag,
    input  wire [cu_pkg::WORD_W-1:0]      host_rdata,
    output logic [cu_pkg::APB_DATA_W-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          start,
    output logic [cu_pkg::INSTR_W-1:0]    instr,
    output logic                          host_we,
    output logic [cu_pkg::REG_SEL_W-1:0]  host_sel,
    output logic [cu_pkg::WORD_W-1:0]     host_data
);

    logic                          access;     // APB access phase
    logic                          is_instr;
    logic                          is_status;
    logic                          is_reg;     // Aligned and below NUM_REGS
    logic [cu_pkg::APB_ADDR_W-1:0] reg_offs;
    logic                          instr_wr;
    logic                          issued;     // Instruction in flight

    assign access    = psel && penable;
    assign reg_offs  = paddr - cu_pkg::ADDR_REG_BASE;
    assign is_instr  = (paddr == cu_pkg::ADDR_INSTR);
    assign is_status = (paddr == cu_pkg::ADDR_STATUS);
    assign is_reg    = (paddr >= cu_pkg::ADDR_REG_BASE) && (reg_offs[1:0] == 2'b00)
                       && (32'(reg_offs[cu_pkg::APB_ADDR_W-1:2]) < NUM_REGS);
    assign instr_wr  = access && pwrite && is_instr;

    // Refused: unmapped, STATUS write, INSTR read, or trapped
    assign pslverr = access && (!(is_instr || is_status || is_reg)
                                || (pwrite && is_status)
                                || (!pwrite && is_instr)
                                || (instr_wr && trap_flag));

    // Instruction writes wait for write-back, all else is zero wait
    assign pready = access && (!instr_wr || trap_flag || done);

    assign start = instr_wr && !trap_flag && !issued;  // First access cycle only
    assign instr = pwdata[cu_pkg::INSTR_W-1:0];

    assign host_we   = access && pwrite && is_reg;
    assign host_sel  = reg_offs[cu_pkg::REG_SEL_W+1:2];
    assign host_data = pwdata[cu_pkg::WORD_W-1:0];    // Upper bits dropped

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (is_reg) begin
                prdata = cu_pkg::APB_DATA_W'(host_rdata);  // Zero-extended
            end else if (is_status) begin
                prdata = cu_pkg::APB_DATA_W'({trap_flag, carry_flag, sign_flag, zero_flag});
            end
        end
    end

    // Set on issue, cleared as write-back ends the transfer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issued <= 1'b0;
        end else if (start) begin
            issued <= 1'b1;
        end else if (done) begin
            issued <= 1'b0;
        end
    end

    // Nothing left in flight once trapped
    assert property (@(posedge clk) disable iff (reset) trap_flag |-> !issued);

    // Issue to completion is four access cycles, ending with done
    assert property (@(posedge clk) disable iff (reset)
        start |-> ##3 (done && pready));

endmodule

`default_nettype wire

// File: hdl/cu_top.sv
// Control unit top level, an APB slave wrapping the sequencer, register file and ALU
`timescale 1ns/1ps
`default_nettype none

module cu_top #(
    parameter int NUM_REGS = cu_pkg::NUM_REGS_DEF  // 1 to 8
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [cu_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire [cu_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [cu_pkg::APB_DATA_W-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr
);

    // APB port to sequencer
    logic                         start;
    logic                         done;
    logic [cu_pkg::INSTR_W-1:0]   instr;
    logic                         zero_flag;
    logic                         sign_flag;
    logic                         carry_flag;
    logic                         trap_flag;

    // Host register access
    logic                         host_we;
    logic [cu_pkg::REG_SEL_W-1:0] host_sel;
    logic [cu_pkg::WORD_W-1:0]    host_data;
    logic [cu_pkg::WORD_W-1:0]    host_rdata;

    // Sequencer to register file
    logic [cu_pkg::REG_SEL_W-1:0] rd_sel_a;
    logic [cu_pkg::REG_SEL_W-1:0] rd_sel_b;
    logic [cu_pkg::WORD_W-1:0]    rd_data_a;
    logic [cu_pkg::WORD_W-1:0]    rd_data_b;
    logic                         wb_we_a;
    logic [cu_pkg::REG_SEL_W-1:0] wb_sel_a;
    logic [cu_pkg::WORD_W-1:0]    wb_data_a;
    logic                         wb_we_b;
    logic [cu_pkg::REG_SEL_W-1:0] wb_sel_b;
    logic [cu_pkg::WORD_W-1:0]    wb_data_b;

    // Sequencer to ALU and back
    cu_pkg::opcode_t              opcode;
    logic [cu_pkg::WORD_W-1:0]    op_a;
    logic [cu_pkg::WORD_W-1:0]    op_b;
    logic [cu_pkg::WORD_W-1:0]    result_a;
    logic [cu_pkg::WORD_W-1:0]    result_b;
    logic                         write_a;
    logic                         write_b;
    logic                         zero_upd;
    logic                         zero_val;
    logic                         sign_upd;
    logic                         sign_val;
    logic                         carry_upd;
    logic                         carry_val;

    cu_apb_port #(.NUM_REGS(NUM_REGS)) u_apb_port (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .instr(instr), .done(done),
        .trap_flag(trap_flag), .zero_flag(zero_flag),
        .sign_flag(sign_flag), .carry_flag(carry_flag),
        .host_we(host_we), .host_sel(host_sel), .host_data(host_data),
        .host_rdata(host_rdata)
    );

    cu_sequencer u_sequencer (
        .clk(clk), .reset(reset), .start(start), .instr(instr), .done(done),
        .zero_flag(zero_flag), .sign_flag(sign_flag),
        .carry_flag(carry_flag), .trap_flag(trap_flag),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wb_we_a(wb_we_a), .wb_sel_a(wb_sel_a), .wb_data_a(wb_data_a),
        .wb_we_b(wb_we_b), .wb_sel_b(wb_sel_b), .wb_data_b(wb_data_b),
        .opcode(opcode), .op_a(op_a), .op_b(op_b),
        .result_a(result_a), .result_b(result_b), .write_a(write_a), .write_b(write_b),
        .zero_upd(zero_upd), .zero_val(zero_val), .sign_upd(sign_upd),
        .sign_val(sign_val), .carry_upd(carry_upd), .carry_val(carry_val)
    );

    cu_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk(clk), .reset(reset),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wb_we_a(wb_we_a), .wb_sel_a(wb_sel_a), .wb_data_a(wb_data_a),
        .wb_we_b(wb_we_b), .wb_sel_b(wb_sel_b), .wb_data_b(wb_data_b),
        .host_we(host_we), .host_sel(host_sel), .host_data(host_data),
        .host_rdata(host_rdata)
    );

    cu_alu u_alu (
        .opcode(opcode), .op_a(op_a), .op_b(op_b),
        .result_a(result_a), .result_b(result_b), .write_a(write_a), .write_b(write_b),
        .zero_upd(zero_upd), .zero_val(zero_val), .sign_upd(sign_upd),
        .sign_val(sign_val), .carry_upd(carry_upd), .carry_val(carry_val)
    );

endmodule

`default_nettype wire

// File: test/tb_cu.sv
// Vector-driven testbench for cu_top, plays APB transfers from the vector file and checks them
`timescale 1ns/1ps
`default_nettype none

module tb_cu;

    localparam int MAX_VECS     = 128;
    localparam int CLK_HALF     = 4;      // 8 ns period
    localparam int DRIVE_DLY    = 1;      // Inputs change 1 ns after the edge
    localparam int RESET_CYCLES = 5;
    localparam int PREADY_WAIT  = 8;      // Longest transfer is four access cycles
    localparam int INSTR_WAITS  = 3;      // pready low in the first three access cycles

    // Vector kinds, first column of the file
    localparam logic [31:0] KIND_WRITE  = 32'h0;
    localparam logic [31:0] KIND_READ   = 32'h1;
    localparam logic [31:0] KIND_WR_ERR = 32'h2;
    localparam logic [31:0] KIND_RD_ERR = 32'h3;
    localparam logic [31:0] KIND_END    = 32'hF;

    logic                          clk;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [cu_pkg::APB_ADDR_W-1:0] paddr;
    logic [cu_pkg::APB_DATA_W-1:0] pwdata;
    logic [cu_pkg::APB_DATA_W-1:0] prdata;
    logic                          pready;
    logic                          pslverr;

    logic [31:0] vec_mem [4*MAX_VECS];  // kind, address, data, expected
    int          num_vecs;
    int          cycle_limit;
    int          cycles;
    int          errors;
    int          checks;

    cu_top #(.NUM_REGS(cu_pkg::NUM_REGS_DEF)) u_dut (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Run limit from the vector count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // One APB transfer, called 1 ns after a rising edge
    task automatic apb_transfer(input logic wr, input logic [cu_pkg::APB_ADDR_W-1:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err, output logic ok, output int waits);
        psel    = 1'b1;                   // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;                   // Access phase
        waits   = 0;
        @(negedge clk);                   // Outputs settled mid-cycle
        while (!pready && waits < PREADY_WAIT) begin
            waits++;
            @(negedge clk);
        end
        ok    = pready;
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                   // Edge that ends the transfer
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Play vector idx and compare pslverr, wait states and read data
    task automatic run_vector(input int idx);
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expect_val;
        logic [31:0] rdata;
        logic        wr;
        logic        exp_err;
        logic        err;
        logic        ok;
        int          waits;
        int          exp_waits;
        kind       = vec_mem[4*idx];
        addr       = vec_mem[4*idx+1];
        data       = vec_mem[4*idx+2];
        expect_val = vec_mem[4*idx+3];
        wr         = (kind == KIND_WRITE) || (kind == KIND_WR_ERR);
        exp_err    = (kind == KIND_WR_ERR) || (kind == KIND_RD_ERR);
        // Only an accepted instruction write waits for write-back
        exp_waits  = (kind == KIND_WRITE && addr[cu_pkg::APB_ADDR_W-1:0] == cu_pkg::ADDR_INSTR)
                     ? INSTR_WAITS : 0;
        assert (kind == KIND_WRITE || kind == KIND_READ || exp_err) else begin
            errors++;
            $display("Vector %0d has an unknown kind %h", idx, kind);
        end
        apb_transfer(wr, addr[cu_pkg::APB_ADDR_W-1:0], data, rdata, err, ok, waits);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Transfer of vector %0d at address %h never got pready", idx, addr[7:0]);
        end
        assert (waits == exp_waits) else begin
            errors++;
            $display("ERR %0t addr %h wait states expected %0d got %0d",
                     $time, addr[7:0], exp_waits, waits);
        end
        assert (err == exp_err) else begin
            errors++;
            $display("ERR %0t addr %h pslverr expected %b got %b",
                     $time, addr[7:0], exp_err, err);
        end
        if (!wr) begin
            assert (rdata == expect_val) else begin  // Refused reads expect zero
                errors++;
                $display("ERR %0t addr %h expected %h got %h",
                         $time, addr[7:0], expect_val, rdata);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        $readmemh("test/cu_vectors.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && vec_mem[4*num_vecs] != KIND_END) begin
            num_vecs++;
        end
        cycle_limit = num_vecs * 6 + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        for (int idx = 0; idx < num_vecs; idx++) begin
            run_vector(idx);
        end
        $display("Errors: %0d in %0d transfers", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/cu_vectors.txt
// kind address data expected, kind 0 write, 1 read, 2 write refused, 3 read refused, F end
// Instruction word is opcode 19:14, src1 13:11, src2 10:8, dst1 7:5, dst2 4:2
0 10 FFF12345 00000000  // r0, upper bits dropped
0 14 000F0F0F 00000000  // r1
0 18 FFFFFFFF 00000000  // r2
1 10 00000000 00012345
2 28 00000001 00000000  // r6 beyond NUM_REGS
2 04 00000000 00000000  // STATUS is read only
3 00 00000000 00000000  // INSTR is write only
0 00 00024180 00000000  // AND r0 r1 to r4
0 00 0002A3A0 00000000  // OR r4 r3 to r5, reads new r4
1 24 00000000 00010305
0 00 0002E480 00000000  // XOR r4 r4 to r4
1 04 00000000 00000001  // Zero set
0 00 00021860 00000000  // NOT r3 to r3
1 1C 00000000 000FFFFF
0 00 00045040 00000000  // INC r2 from FFFFF
1 18 00000000 00000000
1 04 00000000 00000005  // Carry and zero
0 00 00038000 00000000  // ROTR r0
0 00 0003C000 00000000  // ROTL r0
1 04 00000000 00000005  // Flags kept by rotates
1 10 00000000 00012345
0 00 00049040 00000000  // DEC r2 from 0
1 18 00000000 000FFFFF
1 04 00000000 00000004  // Borrow
0 00 00034820 00000000  // SHFTL r1
0 00 00030820 00000000  // SHFTR r1
1 14 00000000 00070F0F
1 04 00000000 00000000
0 00 00040104 00000000  // SWAP r0 r1
1 10 00000000 00070F0F
1 14 00000000 00012345
0 00 000401B4 00000000  // SWAP into r5 twice, port b wins
1 24 00000000 00070F0F
0 00 0005D300 00000000  // EQ r2 r3
1 04 00000000 00000001
0 00 00060100 00000000  // GT r0 r1
1 04 00000000 00000003
0 00 00064100 00000000  // LT r0 r1
1 04 00000000 00000001
0 00 00068800 00000000  // GET r1 r0
1 04 00000000 00000000
0 00 0006C800 00000000  // LET r1 r0
1 04 00000000 00000002
1 10 00000000 00070F0F  // Compares wrote nothing
0 00 00004800 00000000  // NOP
0 00 0004C100 00000000  // ADD decodes as NOP
1 04 00000000 00000002
0 00 00000000 00000000  // TRAP
1 04 00000000 0000000A
2 00 00044000 00000000  // INC refused after trap
1 10 00000000 00070F0F
F 00 00000000 00000000

// File: list.f
common/cu_pkg.sv
datapath/cu_alu.sv
datapath/cu_regfile.sv
control/cu_sequencer.sv
hdl/cu_apb_port.sv
hdl/cu_top.sv
test/tb_cu.sv

// File: Makefile
SIM      := verilator
TOP      := tb_cu
FILELIST := list.f
FLAGS    := --binary --timing --assert -Wno-fatal
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := All checks passed
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
